// ==== avl_bus_macros.svh ====
`ifndef AVL_BUS_MACROS_SVH
`define AVL_BUS_MACROS_SVH

// bus widths.
`define AVL_ADDR_W 32
`define AVL_DATA_W 32
`define AVL_BE_W 4

// number of slaves behind the router.
`define AVL_SLAVE_NUM 4

// reads that may be in flight, power of two.
`define AVL_SEL_FIFO_DEPTH 4

// address map.
// the upper field picks the block, the rest is the local byte address.
`define AVL_MAP_FIELD_LEN 22
`define AVL_LOCAL_ADDR_W 10

// block number of slave 0, slave i sits at base plus i.
`define AVL_MAP_BLOCK_BASE 1

`endif

// ==== avl_bus_pkg.sv ====
`include "avl_bus_macros.svh"

package avl_bus_pkg;

  // master side byte address.
  typedef logic [`AVL_ADDR_W-1:0] addr_t;

  // byte address as seen inside one slave.
  typedef logic [`AVL_LOCAL_ADDR_W-1:0] local_addr_t;

  // read and write data.
  typedef logic [`AVL_DATA_W-1:0] data_t;

  // one enable per data byte.
  typedef logic [`AVL_BE_W-1:0] be_t;

  // slave index.
  typedef logic [$clog2(`AVL_SLAVE_NUM)-1:0] sel_t;

  // response stage of a memory slave.
  // busy means offered for the first time, hold means refused at least once.
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUSY = 2'd1,
    HOLD = 2'd2
  } slv_state_e;

endpackage

// ==== avl_bus_if.sv ====
`include "avl_bus_macros.svh"

interface avl_bus_if
  import avl_bus_pkg::*;
#(
  parameter int ADDR_W = `AVL_ADDR_W
) ();

  // request, driven by the master.
  logic [ADDR_W-1:0] address;
  be_t               byte_en;
  logic              read;
  logic              write;
  data_t             write_data;

  // request accepted when read or write meets request_ready.
  logic              request_ready;

  // response, transfers when valid meets resp_ready.
  data_t             read_data;
  logic              read_data_valid;
  logic              resp_ready;

  modport master (
    output address,
    output byte_en,
    output read,
    output write,
    output write_data,
    output resp_ready,
    input  request_ready,
    input  read_data,
    input  read_data_valid
  );

  modport slave (
    input  address,
    input  byte_en,
    input  read,
    input  write,
    input  write_data,
    input  resp_ready,
    output request_ready,
    output read_data,
    output read_data_valid
  );

endinterface

// ==== avl_addr_decode.sv ====
`include "avl_bus_macros.svh"

module avl_addr_decode
  import avl_bus_pkg::*;
(
  input  addr_t address,
  output sel_t  sel,
  output logic  unmapped
);

  // lowest bit of the block field.
  localparam int FIELD_LSB = `AVL_ADDR_W - `AVL_MAP_FIELD_LEN;

  logic [`AVL_MAP_FIELD_LEN-1:0] block;
  logic [`AVL_SLAVE_NUM-1:0]     hit;

  assign block = address[`AVL_ADDR_W-1:FIELD_LSB];

  // one comparator per slave against its fixed block number.
  for (genvar i = 0; i < `AVL_SLAVE_NUM; i++) begin : g_match
    localparam logic [`AVL_MAP_FIELD_LEN-1:0] BLOCK_NUM =
      `AVL_MAP_FIELD_LEN'(`AVL_MAP_BLOCK_BASE + i);

    assign hit[i] = (block == BLOCK_NUM);
  end

  // blocks do not overlap, so at most one hit.
  // or-ing the indices gives the encoded select.
  always_comb begin
    sel = '0;
    for (int i = 0; i < `AVL_SLAVE_NUM; i++) begin
      if (hit[i]) begin
        sel = sel | sel_t'(i);
      end
    end
  end

  // nothing in the map claims this block.
  assign unmapped = ~|hit;

endmodule

// ==== avl_sel_fifo.sv ====
`include "avl_bus_macros.svh"

module avl_sel_fifo
  import avl_bus_pkg::*;
#(
  parameter int DEPTH = `AVL_SEL_FIFO_DEPTH,
  parameter int WIDTH = $bits(sel_t)
) (
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  logic pop,
  input  sel_t push_data,
  output sel_t head,
  output logic full,
  output logic empty
);

  // depth is a power of two, so the pointers wrap on their own.
  localparam int PTR_W = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;

  // storage.
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers and occupancy.
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone.
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head  = mem[rd_ptr];
  assign full  = (count == (PTR_W + 1)'(DEPTH));
  assign empty = (count == '0);

  // the router must hold off reads once every slot is taken.
  a_no_push_full: assert property (
    @(posedge clk) disable iff (rst)
    !(push && full)
  );

  // a response can only come back for a read that was recorded.
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (rst)
    !(pop && empty)
  );

endmodule

// ==== avl_bus_router.sv ====
`include "avl_bus_macros.svh"

module avl_bus_router
  import avl_bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  avl_bus_if.slave  mst,
  avl_bus_if.master slv [`AVL_SLAVE_NUM],
  output logic      addr_error
);

  sel_t  req_sel;
  logic  unmapped;
  sel_t  head_sel;
  logic  fifo_full;
  logic  fifo_empty;
  logic  fifo_push;
  logic  fifo_pop;
  logic  req_ready;

  // per slave response and ready, gathered so they can be indexed.
  data_t                     slv_rdata [`AVL_SLAVE_NUM];
  logic [`AVL_SLAVE_NUM-1:0] slv_rvalid;
  logic [`AVL_SLAVE_NUM-1:0] slv_rready;

  avl_addr_decode u_decode (
    .address  (mst.address),
    .sel      (req_sel),
    .unmapped (unmapped)
  );

  // request steering.
  for (genvar i = 0; i < `AVL_SLAVE_NUM; i++) begin : g_slv
    logic req_hit;
    logic is_head;

    // the request goes through only if its read can be recorded.
    assign req_hit = (req_sel == sel_t'(i)) && !unmapped && !fifo_full;
    assign is_head = (head_sel == sel_t'(i)) && !fifo_empty;

    assign slv[i].address    = mst.address[`AVL_LOCAL_ADDR_W-1:0];
    assign slv[i].byte_en    = mst.byte_en;
    assign slv[i].write_data = mst.write_data;
    assign slv[i].read       = mst.read && req_hit;
    assign slv[i].write      = mst.write && req_hit;

    // other slaves keep their responses until their turn comes.
    assign slv[i].resp_ready = mst.resp_ready && is_head;

    assign slv_rdata[i]  = slv[i].read_data;
    assign slv_rvalid[i] = slv[i].read_data_valid;
    assign slv_rready[i] = slv[i].request_ready;
  end

  // unmapped requests are swallowed right away.
  assign req_ready = unmapped ? 1'b1 : (slv_rready[req_sel] && !fifo_full);

  assign mst.request_ready = req_ready;
  assign addr_error        = (mst.read || mst.write) && unmapped;

  // read ordering.
  assign fifo_push = mst.read && req_ready && !unmapped;
  assign fifo_pop  = mst.read_data_valid && mst.resp_ready;

  avl_sel_fifo #(
    .DEPTH (`AVL_SEL_FIFO_DEPTH),
    .WIDTH ($bits(sel_t))
  ) u_sel_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (fifo_push),
    .pop       (fifo_pop),
    .push_data (req_sel),
    .head      (head_sel),
    .full      (fifo_full),
    .empty     (fifo_empty)
  );

  // only the oldest outstanding read may answer.
  assign mst.read_data_valid = slv_rvalid[head_sel] && !fifo_empty;
  assign mst.read_data       = slv_rdata[head_sel];

  // with no read in flight no slave has anything to return,
  // so the master never sees a stray valid.
  a_no_resp_when_idle: assert property (
    @(posedge clk) disable iff (rst)
    fifo_empty |-> (slv_rvalid == '0)
  );

endmodule

// ==== avl_mem_slave.sv ====
`include "avl_bus_macros.svh"

module avl_mem_slave
  import avl_bus_pkg::*;
#(
  parameter int LATENCY = 1
) (
  input  logic     clk,
  input  logic     rst,
  avl_bus_if.slave bus
);

  // word index is the local address without the byte offset.
  localparam int IDX_W = `AVL_LOCAL_ADDR_W - 2;

  data_t            mem [2**IDX_W];
  logic [IDX_W-1:0] word_idx;
  slv_state_e       state;
  data_t            out_data;
  logic             advance;
  logic             rd_fire;
  logic             in_vld;
  data_t            in_data;

  assign word_idx = bus.address[`AVL_LOCAL_ADDR_W-1:2];

  // pipeline moves when the output is empty or being taken.
  assign advance = (state == IDLE) || bus.resp_ready;
  assign rd_fire = bus.read && advance;

  // byte merge write.
  always_ff @(posedge clk) begin
    if (bus.write && advance) begin
      for (int b = 0; b < `AVL_BE_W; b++) begin
        if (bus.byte_en[b]) begin
          mem[word_idx][8*b +: 8] <= bus.write_data[8*b +: 8];
        end
      end
    end
  end

  // stages ahead of the output, none for latency one.
  if (LATENCY == 1) begin : g_direct
    assign in_vld  = rd_fire;
    assign in_data = mem[word_idx];
  end else begin : g_pipe
    logic [LATENCY-2:0] vld_q;
    data_t              data_q [LATENCY-1];

    always_ff @(posedge clk) begin
      if (rst) begin
        vld_q <= '0;
      end else if (advance) begin
        vld_q[0] <= rd_fire;
        for (int s = 1; s < LATENCY - 1; s++) begin
          vld_q[s] <= vld_q[s-1];
        end
      end
    end

    always_ff @(posedge clk) begin
      if (advance) begin
        data_q[0] <= mem[word_idx];
        for (int s = 1; s < LATENCY - 1; s++) begin
          data_q[s] <= data_q[s-1];
        end
      end
    end

    assign in_vld  = vld_q[LATENCY-2];
    assign in_data = data_q[LATENCY-2];
  end

  // output stage.
  always_ff @(posedge clk) begin
    if (advance) begin
      out_data <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else if (advance) begin
      state <= in_vld ? BUSY : IDLE;
    end else begin
      state <= HOLD;
    end
  end

  assign bus.request_ready   = advance;
  assign bus.read_data_valid = (state != IDLE);
  assign bus.read_data       = out_data;

  // the router passes on a single master, which never mixes the two.
  a_no_read_write: assert property (
    @(posedge clk) disable iff (rst)
    !(bus.read && bus.write)
  );

  // refused response stays offered and keeps its value.
  a_hold_stable: assert property (
    @(posedge clk) disable iff (rst)
    (bus.read_data_valid && !bus.resp_ready) |=>
      (bus.read_data_valid && $stable(bus.read_data))
  );

endmodule

// ==== avl_bus_top.sv ====
`include "avl_bus_macros.svh"

module avl_bus_top
  import avl_bus_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  addr_t address,
  input  be_t   byte_en,
  input  logic  read,
  input  logic  write,
  input  data_t write_data,
  output logic  request_ready,
  output data_t read_data,
  output logic  read_data_valid,
  input  logic  resp_ready,
  output logic  addr_error
);

  // full width port on the master side.
  avl_bus_if #(.ADDR_W(`AVL_ADDR_W)) mst_bus ();

  // one local width port per slave.
  avl_bus_if #(.ADDR_W(`AVL_LOCAL_ADDR_W)) slv_bus [`AVL_SLAVE_NUM] ();

  assign mst_bus.address    = address;
  assign mst_bus.byte_en    = byte_en;
  assign mst_bus.read       = read;
  assign mst_bus.write      = write;
  assign mst_bus.write_data = write_data;
  assign mst_bus.resp_ready = resp_ready;

  assign request_ready   = mst_bus.request_ready;
  assign read_data       = mst_bus.read_data;
  assign read_data_valid = mst_bus.read_data_valid;

  avl_bus_router u_router (
    .clk        (clk),
    .rst        (rst),
    .mst        (mst_bus.slave),
    .slv        (slv_bus),
    .addr_error (addr_error)
  );

  // slave i answers after i plus one cycles.
  for (genvar i = 0; i < `AVL_SLAVE_NUM; i++) begin : g_slave
    avl_mem_slave #(
      .LATENCY (i + 1)
    ) u_slave (
      .clk (clk),
      .rst (rst),
      .bus (slv_bus[i])
    );
  end

endmodule

// ==== tb_avl_bus_top.sv ====
`include "avl_bus_macros.svh"

module tb_avl_bus_top
  import avl_bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 1000;
  localparam int WORDS = 8;

  logic  clk;
  logic  rst;
  addr_t address;
  be_t   byte_en;
  logic  read;
  logic  write;
  data_t write_data;
  logic  request_ready;
  data_t read_data;
  logic  read_data_valid;
  logic  resp_ready;
  logic  addr_error;

  // byte level copy of every slave memory.
  logic [7:0] model [`AVL_SLAVE_NUM][2**`AVL_LOCAL_ADDR_W];
  // expected read data in issue order.
  data_t      exp_mem [1024];
  int         wr_cnt = 0;
  int         rd_cnt = 0;
  string      test_name = "reset";
  logic       idle_chk;
  logic       bp_on;
  data_t      exp_head;
  logic       exp_addr_error;

  avl_bus_top u_dut (
    .clk             (clk),
    .rst             (rst),
    .address         (address),
    .byte_en         (byte_en),
    .read            (read),
    .write           (write),
    .write_data      (write_data),
    .request_ready   (request_ready),
    .read_data       (read_data),
    .read_data_valid (read_data_valid),
    .resp_ready      (resp_ready),
    .addr_error      (addr_error)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic addr_t word_addr(input int slave, input int word);
    return addr_t'((`AVL_MAP_BLOCK_BASE + slave) << `AVL_LOCAL_ADDR_W) | addr_t'(word * 4);
  endfunction

  function automatic logic is_mapped(input addr_t a);
    int blk;
    blk = int'(a[`AVL_ADDR_W-1:`AVL_LOCAL_ADDR_W]);
    return (blk >= `AVL_MAP_BLOCK_BASE) && (blk < `AVL_MAP_BLOCK_BASE + `AVL_SLAVE_NUM);
  endfunction

  function automatic data_t model_word(input int s, input int off);
    data_t w;
    for (int b = 0; b < `AVL_BE_W; b++) begin
      w[8*b +: 8] = model[s][off + b];
    end
    return w;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  // present one request and hold it until accepted.
  task automatic issue(input logic rd, input addr_t a, input be_t be, input data_t d);
    int n;
    int s;
    int off;
    address    <= a;
    byte_en    <= be;
    read       <= rd;
    write      <= !rd;
    write_data <= d;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) begin
        fail_run($sformatf("%s: request never accepted", test_name));
      end
    end while (!request_ready);
    if (is_mapped(a)) begin
      s   = int'(a[`AVL_ADDR_W-1:`AVL_LOCAL_ADDR_W]) - `AVL_MAP_BLOCK_BASE;
      off = int'(a[`AVL_LOCAL_ADDR_W-1:0]) & ~3;
      if (rd) begin
        exp_mem[wr_cnt] = model_word(s, off);
        wr_cnt++;
      end else begin
        for (int b = 0; b < `AVL_BE_W; b++) begin
          if (be[b]) begin
            model[s][off + b] = d[8*b +: 8];
          end
        end
      end
    end
  endtask

  task automatic idle_bus();
    read  <= 1'b0;
    write <= 1'b0;
  endtask

  // wait until every issued read has come back.
  task automatic drain();
    int n;
    n = 0;
    while (rd_cnt != wr_cnt) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) begin
        fail_run($sformatf("%s: read responses missing", test_name));
      end
    end
  endtask

  task automatic read_back_all();
    for (int s = 0; s < `AVL_SLAVE_NUM; s++) begin
      for (int w = 0; w < WORDS; w++) begin
        issue(1'b1, word_addr(s, w), '1, '0);
      end
    end
    idle_bus();
    drain();
  endtask

  // response counter, one step per transfer.
  always @(posedge clk) begin
    if (!rst && read_data_valid && resp_ready) begin
      rd_cnt <= rd_cnt + 1;
    end
  end

  // oldest read still owed.
  assign exp_head = exp_mem[rd_cnt];

  // strobe due for the request on the bus.
  assign exp_addr_error = (read || write) && !is_mapped(address);

  // random back-pressure on the response side.
  initial begin
    resp_ready = 1'b1;
    forever begin
      @(posedge clk);
      if (bp_on) begin
        resp_ready <= ($urandom % 3) != 0;
      end else begin
        resp_ready <= 1'b1;
      end
    end
  end

  a_reset_idle: assert property (
    @(posedge clk) idle_chk |-> (!read_data_valid && !addr_error && request_ready)
  ) else fail_run("outputs not idle after reset");

  a_read_data: assert property (
    @(posedge clk) disable iff (rst)
    (read_data_valid && resp_ready) |-> (read_data == exp_head)
  ) else fail_run($sformatf("ERROR %s: expected %h, actual %h",
                            test_name, $sampled(exp_head), $sampled(read_data)));

  a_no_extra: assert property (
    @(posedge clk) disable iff (rst)
    read_data_valid |-> (rd_cnt < wr_cnt)
  ) else fail_run($sformatf("%s: response without an outstanding read", test_name));

  a_held_stable: assert property (
    @(posedge clk) disable iff (rst)
    (read_data_valid && !resp_ready) |=> (read_data_valid && $stable(read_data))
  ) else fail_run($sformatf("%s: held response changed or vanished", test_name));

  a_addr_error: assert property (
    @(posedge clk) disable iff (rst)
    addr_error == exp_addr_error
  ) else fail_run($sformatf("ERROR %s: expected addr_error %b, actual %b", test_name,
                            $sampled(exp_addr_error), $sampled(addr_error)));

  initial begin
    void'($urandom(58));
    rst        <= 1'b1;
    address    <= '0;
    byte_en    <= '0;
    read       <= 1'b0;
    write      <= 1'b0;
    write_data <= '0;
    idle_chk   <= 1'b0;
    bp_on      <= 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    // point at each slave in turn so its own ready is seen.
    idle_chk <= 1'b1;
    for (int s = 0; s < `AVL_SLAVE_NUM; s++) begin
      address <= word_addr(s, 0);
      @(posedge clk);
    end
    idle_chk <= 1'b0;

    test_name = "full_word";
    for (int s = 0; s < `AVL_SLAVE_NUM; s++) begin
      for (int w = 0; w < WORDS; w++) begin
        issue(1'b0, word_addr(s, w), '1, $urandom);
      end
    end
    read_back_all();

    test_name = "byte_merge";
    for (int s = 0; s < `AVL_SLAVE_NUM; s++) begin
      issue(1'b0, word_addr(s, 1), 4'b0101, $urandom);
      issue(1'b0, word_addr(s, 2), 4'b1000, $urandom);
      issue(1'b0, word_addr(s, 3), 4'b0010, $urandom);
    end
    read_back_all();

    // slow slave first, then fast ones, no gaps.
    test_name = "order";
    for (int i = 0; i < 12; i++) begin
      issue(1'b1, word_addr(3 - (i % `AVL_SLAVE_NUM), i % WORDS), '1, '0);
    end
    idle_bus();
    drain();

    test_name = "backpressure";
    bp_on <= 1'b1;
    for (int i = 0; i < 60; i++) begin
      issue(($urandom % 2) == 0, word_addr($urandom % `AVL_SLAVE_NUM, $urandom % WORDS),
            be_t'($urandom), $urandom);
    end
    idle_bus();
    drain();
    bp_on <= 1'b0;

    test_name = "unmapped";
    issue(1'b0, addr_t'(32'h0000_0000), '1, $urandom);
    issue(1'b0, addr_t'(32'h0000_2404), '1, $urandom);
    issue(1'b1, addr_t'(32'h8000_0008), '1, '0);
    issue(1'b1, addr_t'(32'h0000_1400), '1, '0);
    idle_bus();
    repeat (8) @(posedge clk);
    read_back_all();

    if (rd_cnt != wr_cnt) begin
      fail_run("response count does not match issued reads");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// ==== filelist.f ====
+incdir+.
avl_bus_pkg.sv
avl_bus_if.sv
avl_addr_decode.sv
avl_sel_fifo.sv
avl_bus_router.sv
avl_mem_slave.sv
avl_bus_top.sv
tb_avl_bus_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the router testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
  --top-module tb_avl_bus_top \
  -f filelist.f \
  -o sim_tb

# the log decides pass or fail, so keep going if the run stops early.
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
  exit 1
fi
exit 0
